/* src/he_pkg.sv */
package he_pkg;

   // log2 of the largest polynomial length
   localparam int MAX_LOG_N = 12;

   localparam int Q_WIDTH    = 30;
   localparam int DATA_WIDTH = 32;
   localparam int ADDR_WIDTH = 32;

   // one residue mod q
   typedef logic [Q_WIDTH-1:0] coeff_t;

   ////////////////////
   // host register map, byte offsets
   typedef enum logic [7:0]
   {
      CSR_Q      = 8'h00,
      CSR_N      = 8'h08,
      CSR_A_PTR  = 8'h10,
      CSR_B_PTR  = 8'h18,
      CSR_WB_PTR = 8'h20,
      CSR_START  = 8'h28,
      CSR_STATUS = 8'h30
   } csr_addr_e;

   ////////////////////
   // dma job kinds
   // lo pair is banks 0/1, hi pair is banks 2/3
   typedef enum logic [1:0]
   {
      DMA_LOAD_LO = 2'd0,
      DMA_LOAD_HI = 2'd1,
      DMA_STORE   = 2'd2,
      DMA_NOTIFY  = 2'd3
   } dma_kind_e;

   // completion write goes here
   localparam logic [ADDR_WIDTH-1:0] INTR_ADDR = 32'h0030_0000;

endpackage

/* src/he_if.sv */
interface dma_job_if
#(
   parameter int log_max_n_p = he_pkg::MAX_LOG_N
);
   import he_pkg::*;

   logic                  start;
   dma_kind_e             kind;
   logic [ADDR_WIDTH-1:0] base;
   logic [log_max_n_p:0]  len;
   logic                  done;

   modport seq (output start, kind, base, len, input done);
   modport dma (input start, kind, base, len, output done);
endinterface

interface bank_port_if
#(
   parameter int log_max_n_p = he_pkg::MAX_LOG_N
);
   import he_pkg::*;

   logic                   rd_en;
   logic [log_max_n_p-2:0] rd_row;
   // bit 0 writes the even bank, bit 1 the odd bank
   logic [1:0]             wr_en;
   logic [log_max_n_p-2:0] wr_row;
   coeff_t                 wr_lo;
   coeff_t                 wr_hi;
   logic                   pair_sel;
   // index 0 is pair 0/1, index 1 is pair 2/3
   coeff_t [1:0]           rd_lo;
   coeff_t [1:0]           rd_hi;

   modport master (output rd_en, rd_row, wr_en, wr_row, wr_lo, wr_hi, pair_sel,
                   input rd_lo, rd_hi);
   modport array (input rd_en, rd_row, wr_en, wr_row, wr_lo, wr_hi, pair_sel,
                  output rd_lo, rd_hi);
endinterface

/* src/he_csr_file.sv */
module he_csr_file
#(
   parameter int log_max_n_p = he_pkg::MAX_LOG_N
)
(
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          csr_cmd_v_i,
   input  logic                          csr_cmd_we_i,
   input  logic [he_pkg::ADDR_WIDTH-1:0] csr_cmd_addr_i,
   input  logic [he_pkg::DATA_WIDTH-1:0] csr_cmd_data_i,
   output logic                          csr_cmd_ready_o,
   output logic                          csr_resp_v_o,
   output logic [he_pkg::DATA_WIDTH-1:0] csr_resp_data_o,
   input  logic                          csr_resp_yumi_i,
   input  logic                          busy_i,
   input  logic                          done_i,
   output he_pkg::coeff_t                q_o,
   output logic [log_max_n_p:0]          n_o,
   output logic [he_pkg::ADDR_WIDTH-1:0] a_ptr_o,
   output logic [he_pkg::ADDR_WIDTH-1:0] b_ptr_o,
   output logic [he_pkg::ADDR_WIDTH-1:0] wb_ptr_o,
   output logic                          start_o
);
   import he_pkg::*;

   logic                  cmd_fire;
   logic                  offset_ok;
   csr_addr_e             offset;
   logic [DATA_WIDTH-1:0] rd_data;

   // one response in flight, so no new command until it is taken
   assign csr_cmd_ready_o = ~csr_resp_v_o;
   assign cmd_fire        = csr_cmd_v_i & csr_cmd_ready_o;

   // registers live in the low byte, anything above it is unmapped
   assign offset_ok = (csr_cmd_addr_i[ADDR_WIDTH-1:8] == '0);
   assign offset    = csr_addr_e'(csr_cmd_addr_i[7:0]);

   always_comb
   begin
      rd_data = '0;
      if (offset_ok)
      begin
         case (offset)
            CSR_Q:      rd_data = DATA_WIDTH'(q_o);
            CSR_N:      rd_data = DATA_WIDTH'(n_o);
            CSR_A_PTR:  rd_data = DATA_WIDTH'(a_ptr_o);
            CSR_B_PTR:  rd_data = DATA_WIDTH'(b_ptr_o);
            CSR_WB_PTR: rd_data = DATA_WIDTH'(wb_ptr_o);
            CSR_STATUS: rd_data = DATA_WIDTH'({done_i, busy_i});
            default:    rd_data = '0;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_fire && csr_cmd_we_i && offset_ok)
      begin
         case (offset)
            CSR_Q:      q_o      <= csr_cmd_data_i[Q_WIDTH-1:0];
            CSR_N:      n_o      <= csr_cmd_data_i[log_max_n_p:0];
            CSR_A_PTR:  a_ptr_o  <= csr_cmd_data_i;
            CSR_B_PTR:  b_ptr_o  <= csr_cmd_data_i;
            CSR_WB_PTR: wb_ptr_o <= csr_cmd_data_i;
            default:    ;
         endcase
      end
      // writes answer with zero
      if (cmd_fire)
         csr_resp_data_o <= csr_cmd_we_i ? '0 : rd_data;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         csr_resp_v_o <= 1'b0;
         start_o      <= 1'b0;
      end
      else
      begin
         if (cmd_fire)
            csr_resp_v_o <= 1'b1;
         else if (csr_resp_yumi_i)
            csr_resp_v_o <= 1'b0;
         start_o <= cmd_fire && csr_cmd_we_i && offset_ok && (offset == CSR_START)
                    && csr_cmd_data_i[0] && !busy_i;
      end
   end

endmodule

/* src/he_sequencer.sv */
module he_sequencer
#(
   parameter int log_max_n_p = he_pkg::MAX_LOG_N
)
(
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          start_i,
   input  logic [log_max_n_p:0]          n_i,
   input  logic [he_pkg::ADDR_WIDTH-1:0] a_ptr_i,
   input  logic [he_pkg::ADDR_WIDTH-1:0] b_ptr_i,
   input  logic [he_pkg::ADDR_WIDTH-1:0] wb_ptr_i,
   input  logic                          add_done_i,
   output logic                          busy_o,
   output logic                          done_o,
   output logic                          add_start_o,
   dma_job_if.seq                        job_o
);
   import he_pkg::*;

   typedef enum logic [2:0]
   {
      IDLE,
      LOAD_A,
      LOAD_B,
      ADD,
      WB_RES,
      NOTIFY,
      FINISH
   } state_e;

   state_e state_r;
   state_e state_n;
   // high in the first cycle of each working state
   logic   launch_r;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         IDLE:
            if (start_i)
               state_n = LOAD_A;
         LOAD_A:
            if (job_o.done)
               state_n = LOAD_B;
         LOAD_B:
            if (job_o.done)
               state_n = ADD;
         ADD:
            if (add_done_i)
               state_n = WB_RES;
         WB_RES:
            if (job_o.done)
               state_n = NOTIFY;
         NOTIFY:
            if (job_o.done)
               state_n = FINISH;
         default:
            state_n = IDLE;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r  <= IDLE;
         launch_r <= 1'b0;
         done_o   <= 1'b0;
      end
      else
      begin
         state_r  <= state_n;
         launch_r <= (state_n != state_r) && (state_n != IDLE) && (state_n != FINISH);
         // sticky until the next job begins
         if (state_r == IDLE && start_i)
            done_o <= 1'b0;
         else if (state_r == NOTIFY && job_o.done)
            done_o <= 1'b1;
      end
   end

   ////////////////////
   // job descriptor for the dma engine
   always_comb
   begin
      job_o.kind = DMA_LOAD_LO;
      job_o.base = a_ptr_i;
      job_o.len  = n_i;
      case (state_r)
         LOAD_B:
         begin
            job_o.kind = DMA_LOAD_HI;
            job_o.base = b_ptr_i;
         end
         WB_RES:
         begin
            job_o.kind = DMA_STORE;
            job_o.base = wb_ptr_i;
         end
         NOTIFY:
         begin
            job_o.kind = DMA_NOTIFY;
            job_o.base = INTR_ADDR;
            job_o.len  = (log_max_n_p + 1)'(1);
         end
         default: ;
      endcase
   end

   assign job_o.start = launch_r && (state_r != ADD);
   assign add_start_o = launch_r && (state_r == ADD);
   assign busy_o      = (state_r != IDLE);

endmodule

/* src/he_dma_engine.sv */
module he_dma_engine
#(
   parameter int log_max_n_p = he_pkg::MAX_LOG_N
)
(
   input  logic                          clk_i,
   input  logic                          reset_i,
   output logic                          mem_cmd_v_o,
   output logic                          mem_cmd_we_o,
   output logic [he_pkg::ADDR_WIDTH-1:0] mem_cmd_addr_o,
   output logic [he_pkg::DATA_WIDTH-1:0] mem_cmd_data_o,
   input  logic                          mem_cmd_yumi_i,
   input  logic                          mem_resp_v_i,
   input  logic [he_pkg::DATA_WIDTH-1:0] mem_resp_data_i,
   dma_job_if.dma                        job_i,
   bank_port_if.master                   bank_o
);
   import he_pkg::*;

   typedef enum logic [1:0]
   {
      IDLE,
      CMD,
      WAIT
   } state_e;

   state_e                state_r;
   dma_kind_e             kind_r;
   logic [ADDR_WIDTH-1:0] base_r;
   logic [log_max_n_p:0]  len_r;
   logic [log_max_n_p:0]  count_r;
   logic [log_max_n_p:0]  count_nx;
   logic                  last_beat;
   logic                  resp_fire;
   coeff_t                store_word;

   assign count_nx  = count_r + 1'b1;
   assign last_beat = (count_nx == len_r);
   assign resp_fire = (state_r == WAIT) && mem_resp_v_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r    <= IDLE;
         kind_r     <= DMA_LOAD_LO;
         count_r    <= '0;
         job_i.done <= 1'b0;
      end
      else
      begin
         job_i.done <= 1'b0;
         case (state_r)
            IDLE:
               if (job_i.start)
               begin
                  state_r <= CMD;
                  kind_r  <= job_i.kind;
                  count_r <= '0;
               end
            // held here under back-pressure
            CMD:
               if (mem_cmd_yumi_i)
                  state_r <= WAIT;
            WAIT:
               if (mem_resp_v_i)
               begin
                  if (last_beat)
                  begin
                     state_r    <= IDLE;
                     job_i.done <= 1'b1;
                  end
                  else
                  begin
                     state_r <= CMD;
                     count_r <= count_nx;
                  end
               end
            default:
               state_r <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (state_r == IDLE && job_i.start)
      begin
         base_r <= job_i.base;
         len_r  <= job_i.len;
      end
   end

   ////////////////////
   // memory command
   assign mem_cmd_v_o    = (state_r == CMD);
   assign mem_cmd_we_o   = (kind_r == DMA_STORE) || (kind_r == DMA_NOTIFY);
   assign mem_cmd_addr_o = base_r + ADDR_WIDTH'({count_r, 2'b00});
   assign store_word     = count_r[0] ? bank_o.rd_hi[1] : bank_o.rd_lo[1];

   always_comb
   begin
      case (kind_r)
         DMA_STORE:  mem_cmd_data_o = DATA_WIDTH'(store_word);
         DMA_NOTIFY: mem_cmd_data_o = DATA_WIDTH'(1);
         default:    mem_cmd_data_o = '0;
      endcase
   end

   ////////////////////
   // bank side
   // loads fill the pair named by the job, stores drain pair 2/3
   assign bank_o.pair_sel = (state_r == IDLE) ? (job_i.kind != DMA_LOAD_LO)
                                              : (kind_r != DMA_LOAD_LO);
   assign bank_o.wr_en    = (resp_fire && !mem_cmd_we_o) ? {count_r[0], ~count_r[0]} : 2'b00;
   assign bank_o.wr_row   = count_r[log_max_n_p-1:1];
   assign bank_o.wr_lo    = mem_resp_data_i[Q_WIDTH-1:0];
   assign bank_o.wr_hi    = mem_resp_data_i[Q_WIDTH-1:0];

   // the word for the next store is fetched one cycle ahead of its command
   assign bank_o.rd_en  = (state_r == IDLE && job_i.start && job_i.kind == DMA_STORE)
                          || (resp_fire && kind_r == DMA_STORE && !last_beat);
   assign bank_o.rd_row = (state_r == IDLE) ? '0 : count_nx[log_max_n_p-1:1];

endmodule

/* src/he_bank_array.sv */
module he_bank_array
#(
   parameter int log_max_n_p = he_pkg::MAX_LOG_N
)
(
   input  logic       clk_i,
   bank_port_if.array dma_i,
   bank_port_if.array alu_i
);
   import he_pkg::*;

   localparam int rows_lp = 2 ** (log_max_n_p - 1);

   // banks 0/1 hold A, banks 2/3 hold B and then the sums
   for (genvar gi = 0; gi < 4; gi++)
   begin : g_bank
      localparam logic pair_lp = 1'(gi / 2);
      localparam int   lane_lp = gi % 2;

      coeff_t mem [rows_lp];
      coeff_t q_r;
      logic   alu_wr;
      logic   dma_wr;
      logic   alu_rd;
      logic   dma_rd;
      coeff_t alu_wdata;
      coeff_t dma_wdata;

      assign alu_wr    = alu_i.wr_en[lane_lp] && (alu_i.pair_sel == pair_lp);
      assign dma_wr    = dma_i.wr_en[lane_lp] && (dma_i.pair_sel == pair_lp);
      // the adder reads pair 0/1 together with whichever pair it selects
      assign alu_rd    = alu_i.rd_en && ((alu_i.pair_sel == pair_lp) || (pair_lp == 1'b0));
      assign dma_rd    = dma_i.rd_en && (dma_i.pair_sel == pair_lp);
      assign alu_wdata = (lane_lp == 1) ? alu_i.wr_hi : alu_i.wr_lo;
      assign dma_wdata = (lane_lp == 1) ? dma_i.wr_hi : dma_i.wr_lo;

      always_ff @(posedge clk_i)
      begin
         if (alu_wr)
            mem[alu_i.wr_row] <= alu_wdata;
         else if (dma_wr)
            mem[dma_i.wr_row] <= dma_wdata;
         if (alu_rd)
            q_r <= mem[alu_i.rd_row];
         else if (dma_rd)
            q_r <= mem[dma_i.rd_row];
      end
   end

   assign alu_i.rd_lo = {g_bank[2].q_r, g_bank[0].q_r};
   assign alu_i.rd_hi = {g_bank[3].q_r, g_bank[1].q_r};
   assign dma_i.rd_lo = {g_bank[2].q_r, g_bank[0].q_r};
   assign dma_i.rd_hi = {g_bank[3].q_r, g_bank[1].q_r};

endmodule

/* src/he_modadd_unit.sv */
module he_modadd_unit
#(
   parameter int log_max_n_p = he_pkg::MAX_LOG_N
)
(
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 start_i,
   input  logic [log_max_n_p:0] n_i,
   input  he_pkg::coeff_t       q_i,
   output logic                 done_o,
   bank_port_if.master          bank_o
);
   import he_pkg::*;

   logic                   active_r;
   logic [log_max_n_p-2:0] row_r;
   logic [log_max_n_p-2:0] last_row_r;
   logic [log_max_n_p-1:0] half_m1;
   logic                   v1_r;
   logic                   v2_r;
   logic [log_max_n_p-2:0] row1_r;
   logic [log_max_n_p-2:0] row2_r;
   coeff_t                 sum_lo_r;
   coeff_t                 sum_hi_r;

   // inputs are already reduced, so one conditional subtract suffices
   function automatic coeff_t mod_add(coeff_t a, coeff_t b, coeff_t q);
      logic [Q_WIDTH:0] sum;
      sum = {1'b0, a} + {1'b0, b};
      if (sum >= {1'b0, q})
         sum = sum - {1'b0, q};
      return sum[Q_WIDTH-1:0];
   endfunction

   assign half_m1 = n_i[log_max_n_p:1] - 1'b1;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         active_r <= 1'b0;
         v1_r     <= 1'b0;
         v2_r     <= 1'b0;
         done_o   <= 1'b0;
      end
      else
      begin
         if (start_i)
            active_r <= 1'b1;
         else if (active_r && row_r == last_row_r)
            active_r <= 1'b0;
         v1_r   <= active_r;
         v2_r   <= v1_r;
         done_o <= v2_r && (row2_r == last_row_r);
      end
   end

   ////////////////////
   // row sweep and two-stage pipe
   always_ff @(posedge clk_i)
   begin
      if (start_i)
      begin
         row_r      <= '0;
         last_row_r <= half_m1[log_max_n_p-2:0];
      end
      else if (active_r)
         row_r <= row_r + 1'b1;
      row1_r   <= row_r;
      row2_r   <= row1_r;
      sum_lo_r <= mod_add(bank_o.rd_lo[0], bank_o.rd_lo[1], q_i);
      sum_hi_r <= mod_add(bank_o.rd_hi[0], bank_o.rd_hi[1], q_i);
   end

   // read B from 2/3 and write sums back over it
   assign bank_o.pair_sel = 1'b1;
   assign bank_o.rd_en    = active_r;
   assign bank_o.rd_row   = row_r;
   assign bank_o.wr_en    = {v2_r, v2_r};
   assign bank_o.wr_row   = row2_r;
   assign bank_o.wr_lo    = sum_lo_r;
   assign bank_o.wr_hi    = sum_hi_r;

endmodule

/* src/he_accel_top.sv */
module he_accel_top
#(
   parameter int log_max_n_p = he_pkg::MAX_LOG_N
)
(
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          csr_cmd_v_i,
   input  logic                          csr_cmd_we_i,
   input  logic [he_pkg::ADDR_WIDTH-1:0] csr_cmd_addr_i,
   input  logic [he_pkg::DATA_WIDTH-1:0] csr_cmd_data_i,
   output logic                          csr_cmd_ready_o,
   output logic                          csr_resp_v_o,
   output logic [he_pkg::DATA_WIDTH-1:0] csr_resp_data_o,
   input  logic                          csr_resp_yumi_i,
   output logic                          mem_cmd_v_o,
   output logic                          mem_cmd_we_o,
   output logic [he_pkg::ADDR_WIDTH-1:0] mem_cmd_addr_o,
   output logic [he_pkg::DATA_WIDTH-1:0] mem_cmd_data_o,
   input  logic                          mem_cmd_yumi_i,
   input  logic                          mem_resp_v_i,
   input  logic [he_pkg::DATA_WIDTH-1:0] mem_resp_data_i
);
   import he_pkg::*;

   coeff_t                q;
   logic [log_max_n_p:0]  n;
   logic [ADDR_WIDTH-1:0] a_ptr;
   logic [ADDR_WIDTH-1:0] b_ptr;
   logic [ADDR_WIDTH-1:0] wb_ptr;
   logic                  start;
   logic                  busy;
   logic                  done;
   logic                  add_start;
   logic                  add_done;

   dma_job_if   #(.log_max_n_p(log_max_n_p)) job ();
   bank_port_if #(.log_max_n_p(log_max_n_p)) dma_bank ();
   bank_port_if #(.log_max_n_p(log_max_n_p)) alu_bank ();

   he_csr_file #(.log_max_n_p(log_max_n_p)) csr0 (
      .clk_i, .reset_i,
      .csr_cmd_v_i, .csr_cmd_we_i, .csr_cmd_addr_i, .csr_cmd_data_i, .csr_cmd_ready_o,
      .csr_resp_v_o, .csr_resp_data_o, .csr_resp_yumi_i,
      .busy_i(busy), .done_i(done),
      .q_o(q), .n_o(n), .a_ptr_o(a_ptr), .b_ptr_o(b_ptr), .wb_ptr_o(wb_ptr),
      .start_o(start)
   );

   he_sequencer #(.log_max_n_p(log_max_n_p)) seq0 (
      .clk_i, .reset_i, .start_i(start), .n_i(n),
      .a_ptr_i(a_ptr), .b_ptr_i(b_ptr), .wb_ptr_i(wb_ptr), .add_done_i(add_done),
      .busy_o(busy), .done_o(done), .add_start_o(add_start), .job_o(job)
   );

   he_dma_engine #(.log_max_n_p(log_max_n_p)) dma0 (
      .clk_i, .reset_i,
      .mem_cmd_v_o, .mem_cmd_we_o, .mem_cmd_addr_o, .mem_cmd_data_o, .mem_cmd_yumi_i,
      .mem_resp_v_i, .mem_resp_data_i,
      .job_i(job), .bank_o(dma_bank)
   );

   he_bank_array #(.log_max_n_p(log_max_n_p)) banks0 (
      .clk_i, .dma_i(dma_bank), .alu_i(alu_bank)
   );

   he_modadd_unit #(.log_max_n_p(log_max_n_p)) add0 (
      .clk_i, .reset_i, .start_i(add_start), .n_i(n), .q_i(q),
      .done_o(add_done), .bank_o(alu_bank)
   );

endmodule

/* tests/he_accel_tb.sv */
module he_accel_tb;
   import he_pkg::*;

   localparam int log_max_n_lp       = 8;
   localparam int drive_delay_lp     = 10;
   localparam int jobs_lp            = 2;
   localparam int longest_n_lp       = 24;
   localparam int watchdog_cycles_lp = jobs_lp * (4 * longest_n_lp + 20) * 10 + 2000;

   logic                  clk_i;
   logic                  reset_i;
   logic                  csr_cmd_v_i;
   logic                  csr_cmd_we_i;
   logic [ADDR_WIDTH-1:0] csr_cmd_addr_i;
   logic [DATA_WIDTH-1:0] csr_cmd_data_i;
   logic                  csr_cmd_ready_o;
   logic                  csr_resp_v_o;
   logic [DATA_WIDTH-1:0] csr_resp_data_o;
   logic                  csr_resp_yumi_i;
   logic                  mem_cmd_v_o;
   logic                  mem_cmd_we_o;
   logic [ADDR_WIDTH-1:0] mem_cmd_addr_o;
   logic [DATA_WIDTH-1:0] mem_cmd_data_o;
   logic                  mem_cmd_yumi_i;
   logic                  mem_resp_v_i;
   logic [DATA_WIDTH-1:0] mem_resp_data_i;

   // memory model state, shared with the job checks
   logic [31:0] mem_words [logic [31:0]];
   int          store_count;
   int          stores_at_notify;
   int          notify_resp_count;
   logic        last_cmd_we;
   logic [31:0] last_cmd_addr;
   logic [31:0] last_cmd_data;
   logic        outstanding;
   int          value_errors;
   int          protocol_errors;

   he_accel_top #(.log_max_n_p(log_max_n_lp)) dut0 (
      .clk_i, .reset_i,
      .csr_cmd_v_i, .csr_cmd_we_i, .csr_cmd_addr_i, .csr_cmd_data_i, .csr_cmd_ready_o,
      .csr_resp_v_o, .csr_resp_data_o, .csr_resp_yumi_i,
      .mem_cmd_v_o, .mem_cmd_we_o, .mem_cmd_addr_o, .mem_cmd_data_o, .mem_cmd_yumi_i,
      .mem_resp_v_i, .mem_resp_data_i
   );

   initial
   begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   ////////////////////
   // protocol checks
   always @(posedge clk_i)
   begin
      if (reset_i)
         outstanding <= 1'b0;
      else if (mem_cmd_v_o && mem_cmd_yumi_i)
         outstanding <= 1'b1;
      else if (mem_resp_v_i)
         outstanding <= 1'b0;
   end

   hold_mem_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_cmd_v_o && !mem_cmd_yumi_i |=> mem_cmd_v_o && $stable(mem_cmd_addr_o)
      && $stable(mem_cmd_we_o) && $stable(mem_cmd_data_o))
   else
   begin
      protocol_errors++;
      $display("memory command changed or dropped before it was accepted at %0t", $time);
   end

   single_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
      !(mem_cmd_v_o && outstanding))
   else
   begin
      protocol_errors++;
      $display("new memory command presented before the previous response at %0t", $time);
   end

   resp_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
      csr_cmd_v_i && csr_cmd_ready_o |=> csr_resp_v_o)
   else
   begin
      protocol_errors++;
      $display("host response did not follow its command by one cycle at %0t", $time);
   end

   hold_csr_resp: assert property (@(posedge clk_i) disable iff (reset_i)
      csr_resp_v_o && !csr_resp_yumi_i |=> csr_resp_v_o && $stable(csr_resp_data_o))
   else
   begin
      protocol_errors++;
      $display("host response dropped or changed before yumi at %0t", $time);
   end

   ////////////////////
   // memory model
   // unwritten words read back as a pattern of the whole address
   function automatic logic [31:0] read_word(input logic [31:0] addr);
      if (mem_words.exists(addr))
         return mem_words[addr];
      return {addr[15:0], addr[31:16]} ^ 32'h5a5a_5a5a;
   endfunction

   initial
   begin : memory_model
      logic        fire;
      logic        cmd_we;
      logic [31:0] cmd_addr;
      logic [31:0] cmd_data;
      logic [31:0] resp_word;
      logic        pending;
      logic        pend_notify;
      int unsigned gap;
      int unsigned stall;
      mem_cmd_yumi_i    = 1'b0;
      mem_resp_v_i      = 1'b0;
      mem_resp_data_i   = '0;
      store_count       = 0;
      stores_at_notify  = 0;
      notify_resp_count = 0;
      pending           = 1'b0;
      pend_notify       = 1'b0;
      stall             = 0;
      gap               = 0;
      resp_word         = '0;
      forever
      begin
         // sample at the falling edge, act after the rising one
         @(negedge clk_i);
         fire     = mem_cmd_v_o && mem_cmd_yumi_i;
         cmd_we   = mem_cmd_we_o;
         cmd_addr = mem_cmd_addr_o;
         cmd_data = mem_cmd_data_o;
         @(posedge clk_i);
         #drive_delay_lp;
         mem_resp_v_i = 1'b0;
         if (fire)
         begin
            last_cmd_we   = cmd_we;
            last_cmd_addr = cmd_addr;
            last_cmd_data = cmd_data;
            pend_notify   = cmd_we && (cmd_addr == INTR_ADDR);
            resp_word     = cmd_we ? '0 : read_word(cmd_addr);
            if (cmd_we)
               mem_words[cmd_addr] = cmd_data;
            if (pend_notify)
               stores_at_notify = store_count;
            else if (cmd_we)
               store_count++;
            pending = 1'b1;
            gap     = $urandom % 4;
         end
         if (pending && gap == 0)
         begin
            mem_resp_v_i    = 1'b1;
            mem_resp_data_i = resp_word;
            pending         = 1'b0;
            if (pend_notify)
               notify_resp_count++;
         end
         else if (pending)
            gap--;
         // yumi high for one cycle, then low for a random stretch
         if (stall == 0)
         begin
            mem_cmd_yumi_i = 1'b1;
            stall          = $urandom % 4;
         end
         else
         begin
            mem_cmd_yumi_i = 1'b0;
            stall--;
         end
      end
   end

   ////////////////////
   // host side
   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         value_errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", what, expected, actual);
      end
   endtask

   task automatic host_transfer(input logic we, input logic [31:0] addr,
                                input logic [31:0] wdata, input int hold,
                                output logic [31:0] rdata);
      @(posedge clk_i);
      #drive_delay_lp;
      csr_cmd_v_i    = 1'b1;
      csr_cmd_we_i   = we;
      csr_cmd_addr_i = addr;
      csr_cmd_data_i = wdata;
      do
         @(negedge clk_i);
      while (!csr_cmd_ready_o);
      @(posedge clk_i);
      #drive_delay_lp;
      csr_cmd_v_i = 1'b0;
      @(negedge clk_i);
      rdata = csr_resp_data_o;
      // response is held here while yumi stays low
      repeat (hold + 1) @(posedge clk_i);
      #drive_delay_lp;
      csr_resp_yumi_i = 1'b1;
      @(posedge clk_i);
      #drive_delay_lp;
      csr_resp_yumi_i = 1'b0;
   endtask

   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] resp;
      host_transfer(1'b1, addr, data, $urandom % 3, resp);
      check_value($sformatf("write response at %h", addr), 32'h0, resp);
   endtask

   task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
      host_transfer(1'b0, addr, 32'h0, $urandom % 4, data);
   endtask

   task automatic run_job(input string name, input int n, input logic [31:0] q,
                          input logic [31:0] a_ptr, input logic [31:0] b_ptr,
                          input logic [31:0] wb_ptr);
      logic [31:0] a_val;
      logic [31:0] b_val;
      logic [31:0] expected [64];
      logic [31:0] rdata;
      int          store_base;
      int          notify_base;
      int          polls;
      for (int i = 0; i < n; i++)
      begin
         // every third pair sums past q
         if (i % 3 == 0)
         begin
            a_val = q - 1 - ($urandom % 200);
            b_val = q - 1 - ($urandom % 200);
         end
         else
         begin
            a_val = $urandom % q;
            b_val = $urandom % q;
         end
         mem_words[a_ptr + 4 * i] = a_val;
         mem_words[b_ptr + 4 * i] = b_val;
         expected[i] = 32'((64'(a_val) + 64'(b_val)) % 64'(q));
      end
      write_reg(32'(CSR_Q), q);
      write_reg(32'(CSR_N), n);
      write_reg(32'(CSR_A_PTR), a_ptr);
      write_reg(32'(CSR_B_PTR), b_ptr);
      write_reg(32'(CSR_WB_PTR), wb_ptr);
      read_reg(32'(CSR_Q), rdata);
      check_value({name, " q readback"}, q, rdata);
      read_reg(32'(CSR_N), rdata);
      check_value({name, " n readback"}, n, rdata);
      read_reg(32'(CSR_A_PTR), rdata);
      check_value({name, " a_ptr readback"}, a_ptr, rdata);
      read_reg(32'(CSR_B_PTR), rdata);
      check_value({name, " b_ptr readback"}, b_ptr, rdata);
      read_reg(32'(CSR_WB_PTR), rdata);
      check_value({name, " wb_ptr readback"}, wb_ptr, rdata);

      store_base  = store_count;
      notify_base = notify_resp_count;
      write_reg(32'(CSR_START), 32'h1);
      wait (notify_resp_count == notify_base + 1);
      polls = 0;
      rdata = 32'h1;
      while (rdata[0] && polls < 32)
      begin
         read_reg(32'(CSR_STATUS), rdata);
         polls++;
      end
      check_value({name, " status after notify"}, 32'h2, rdata);
      check_value({name, " stores before notify"}, n, stores_at_notify - store_base);
      check_value({name, " last command address"}, INTR_ADDR, last_cmd_addr);
      check_value({name, " last command write"}, 32'h1, last_cmd_we);
      check_value({name, " last command data"}, 32'h1, last_cmd_data);
      for (int i = 0; i < n; i++)
         check_value($sformatf("%s result[%0d]", name, i), expected[i],
                     read_word(wb_ptr + 4 * i));
   endtask

   initial
   begin : watchdog
      repeat (watchdog_cycles_lp) @(posedge clk_i);
      $display("timeout: the run did not finish within %0d cycles", watchdog_cycles_lp);
      $display("Verification failed");
      $finish;
   end

   initial
   begin : main
      logic [31:0] rdata;
      void'($urandom(42));
      value_errors    = 0;
      protocol_errors = 0;
      csr_cmd_v_i     = 1'b0;
      csr_cmd_we_i    = 1'b0;
      csr_cmd_addr_i  = '0;
      csr_cmd_data_i  = '0;
      csr_resp_yumi_i = 1'b0;
      reset_i         = 1'b1;
      repeat (5) @(posedge clk_i);
      #drive_delay_lp;
      reset_i = 1'b0;
      @(negedge clk_i);
      check_value("reset mem_cmd_v_o", 32'h0, mem_cmd_v_o);
      check_value("reset csr_resp_v_o", 32'h0, csr_resp_v_o);
      check_value("reset csr_cmd_ready_o", 32'h1, csr_cmd_ready_o);
      read_reg(32'(CSR_STATUS), rdata);
      check_value("reset status", 32'h0, rdata);
      read_reg(32'h0000_0038, rdata);
      check_value("unmapped offset 0x38", 32'h0, rdata);
      read_reg(32'h0000_0108, rdata);
      check_value("unmapped offset 0x108", 32'h0, rdata);

      run_job("job0", 16, 32'h3fff_ffc1, 32'h0000_1000, 32'h0000_2000, 32'h0000_3000);
      run_job("job1", 24, 32'h3fff_ff8d, 32'h0000_4100, 32'h0000_5200, 32'h0000_6300);

      $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* project.f */
src/he_pkg.sv
src/he_if.sv
src/he_csr_file.sv
src/he_sequencer.sv
src/he_dma_engine.sv
src/he_bank_array.sv
src/he_modadd_unit.sv
src/he_accel_top.sv
tests/he_accel_tb.sv

/* Bender.yml */
package:
  name: he_accel

sources:
  - src/he_pkg.sv
  - src/he_if.sv
  - src/he_csr_file.sv
  - src/he_sequencer.sv
  - src/he_dma_engine.sv
  - src/he_bank_array.sv
  - src/he_modadd_unit.sv
  - src/he_accel_top.sv
  - target: test
    files:
      - tests/he_accel_tb.sv
